// File: common/mipsDefines.svh
/*
 * MIPS core sizes
 * data and register index widths, memory depth and the I/O register map
 */

`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

`define MIPS_WIDTH      32      // machine word
`define MIPS_REG_BITS   5       // 32 registers
`define MIPS_MEM_WORDS  2048    // external memory, in words

// memory-mapped I/O inside the register file
`define MIPS_SW_REG     14      // mirrors the switches
`define MIPS_LED_REG    15      // low half drives the leds
`define MIPS_IO_BITS    16

`endif

// File: common/mipsPkg.sv
/*
 * MIPS core types
 * instruction encodings, ALU operations, controller states and the
 * control and memory request bundles
 */

`default_nettype none

package mipsPkg;

`include "mipsDefines.svh"

    typedef logic [`MIPS_WIDTH-1:0]    word_t;
    typedef logic [`MIPS_REG_BITS-1:0] regIdx_t;

    typedef enum logic [5:0] {
        opcRType = 6'b000000,
        opcJ     = 6'b000010,
        opcBeq   = 6'b000100,
        opcAddi  = 6'b001000,
        opcOri   = 6'b001101,
        opcLw    = 6'b100011,
        opcSw    = 6'b101011
    } opcode_e;

    typedef enum logic [5:0] {
        fnAdd = 6'b100000,
        fnSub = 6'b100010,
        fnAnd = 6'b100100,
        fnOr  = 6'b100101,
        fnSlt = 6'b101010
    } funct_e;

    typedef enum logic [2:0] {
        opAdd,
        opSub,
        opAnd,
        opOr,
        opSlt
    } aluOp_e;

    typedef enum logic [3:0] {
        fetch,
        decode,
        memAddr,
        memRead,
        memWrite,
        memWriteBack,
        rExec,
        iExec,
        aluWriteBack,
        branch,
        jump
    } ctrlState_e;

    typedef struct packed {
        logic       irWrite;
        logic       pcWrite;
        logic       pcWriteCond;
        logic       regWrite;
        logic       regDst;      // 1 selects rd, 0 selects rt
        logic       memToReg;
        logic       iOrD;        // 1 addresses data via ALUOut
        logic       memWrite;
        logic       aluSrcA;     // 0 pc, 1 A
        logic [1:0] aluSrcB;     // B, 1, sign imm, zero imm
        logic [1:0] pcSource;    // alu result, ALUOut, jump target
        aluOp_e     aluOp;
    } ctrl_t;

    typedef struct packed {
        logic  strobe;
        word_t addr;
        word_t data;
    } memReq_t;

endpackage

`default_nettype wire

// File: cpu/alu.sv
/*
 * ALU
 * add, subtract, and, or and signed set-less-than, with a zero flag
 */

`timescale 1ns/1ps
`default_nettype none

module alu
(
    input  mipsPkg::word_t  a,
    input  mipsPkg::word_t  b,
    input  mipsPkg::aluOp_e aluOp,
    output mipsPkg::word_t  result,
    output logic            zero
);

    import mipsPkg::*;

    always_comb
    begin
        case (aluOp)
            opSub:   result = a - b;
            opAnd:   result = a & b;
            opOr:    result = a | b;
            opSlt:   result = word_t'($signed(a) < $signed(b));
            default: result = a + b;
        endcase
    end

    assign zero = (result == '0);   // beq compares through opSub

endmodule

`default_nettype wire

// File: cpu/regFile.sv
/*
 * Register file
 * 32 words, two read ports and one write port; r0 reads zero,
 * r14 follows the switches and r15 drives the leds
 */

`timescale 1ns/1ps
`default_nettype none

`include "mipsDefines.svh"

module regFile
(
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      regWrite,
    input  mipsPkg::regIdx_t         readAddr1,
    input  mipsPkg::regIdx_t         readAddr2,
    input  mipsPkg::regIdx_t         writeAddr,
    input  mipsPkg::word_t           writeData,
    output mipsPkg::word_t           readData1,
    output mipsPkg::word_t           readData2,
    input  wire [`MIPS_IO_BITS-1:0]  switches,
    output logic [`MIPS_IO_BITS-1:0] leds
);

    import mipsPkg::*;

    localparam regIdx_t SwReg = regIdx_t'(`MIPS_SW_REG);
    localparam regIdx_t LedReg = regIdx_t'(`MIPS_LED_REG);

    word_t regs [1<<`MIPS_REG_BITS];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < (1 << `MIPS_REG_BITS); i++)
                regs[i] <= '0;
        end
        else
        begin
            if (regWrite && writeAddr != '0 && writeAddr != SwReg)
                regs[writeAddr] <= writeData;
            regs[SwReg] <= word_t'(switches);   // refreshed every cycle
        end
    end

    assign readData1 = (readAddr1 == '0) ? '0 : regs[readAddr1];
    assign readData2 = (readAddr2 == '0) ? '0 : regs[readAddr2];
    assign leds      = regs[LedReg][`MIPS_IO_BITS-1:0];

endmodule

`default_nettype wire

// File: cpu/controller.sv
/*
 * Multicycle controller
 * one state per clock, control bundle decoded from the state
 * plus the PC enable for jumps and taken branches
 */

`timescale 1ns/1ps
`default_nettype none

module controller
(
    input  wire              clk,
    input  wire              reset,
    input  mipsPkg::opcode_e opcode,
    input  mipsPkg::funct_e  funct,
    input  wire              zero,
    output mipsPkg::ctrl_t   ctrl,
    output logic             pcEn
);

    import mipsPkg::*;

    ctrlState_e state;
    ctrlState_e nextState;

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= fetch;
        else
            state <= nextState;
    end

    always_comb
    begin
        nextState = fetch;   // everything else ends the instruction
        case (state)
            fetch:    nextState = decode;
            decode:
            begin
                case (opcode)
                    opcRType: nextState = rExec;
                    opcJ:     nextState = jump;
                    opcBeq:   nextState = branch;
                    opcAddi,
                    opcOri:   nextState = iExec;
                    opcLw,
                    opcSw:    nextState = memAddr;
                    default:  nextState = fetch;   // unknown op is a no-op
                endcase
            end
            memAddr:  nextState = (opcode == opcLw) ? memRead : memWrite;
            memRead:  nextState = memWriteBack;
            rExec,
            iExec:    nextState = aluWriteBack;
            default:  nextState = fetch;
        endcase
    end

    always_comb
    begin
        ctrl       = '0;
        ctrl.aluOp = opAdd;
        case (state)
            fetch:
            begin
                ctrl.irWrite = 1'b1;
                ctrl.pcWrite = 1'b1;
                ctrl.aluSrcB = 2'b01;   // pc + 1
            end
            decode:       ctrl.aluSrcB = 2'b10;   // branch target into ALUOut
            memAddr:
            begin
                ctrl.aluSrcA = 1'b1;
                ctrl.aluSrcB = 2'b10;
            end
            memRead:      ctrl.iOrD = 1'b1;
            memWrite:
            begin
                ctrl.iOrD     = 1'b1;
                ctrl.memWrite = 1'b1;
            end
            memWriteBack:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.memToReg = 1'b1;
            end
            rExec:
            begin
                ctrl.aluSrcA = 1'b1;
                case (funct)
                    fnSub:   ctrl.aluOp = opSub;
                    fnAnd:   ctrl.aluOp = opAnd;
                    fnOr:    ctrl.aluOp = opOr;
                    fnSlt:   ctrl.aluOp = opSlt;
                    default: ctrl.aluOp = opAdd;
                endcase
            end
            iExec:
            begin
                ctrl.aluSrcA = 1'b1;
                if (opcode == opcOri)
                begin
                    ctrl.aluSrcB = 2'b11;   // ori takes a zero-extended immediate
                    ctrl.aluOp   = opOr;
                end
                else
                    ctrl.aluSrcB = 2'b10;
            end
            aluWriteBack:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.regDst   = (opcode == opcRType);
            end
            branch:
            begin
                ctrl.aluSrcA     = 1'b1;
                ctrl.aluOp       = opSub;   // equal when zero
                ctrl.pcWriteCond = 1'b1;
                ctrl.pcSource    = 2'b01;
            end
            jump:
            begin
                ctrl.pcWrite  = 1'b1;
                ctrl.pcSource = 2'b10;
            end
            default:      ctrl.aluOp = opAdd;
        endcase
    end

    assign pcEn = ctrl.pcWrite | (ctrl.pcWriteCond & zero);

endmodule

`default_nettype wire

// File: cpu/datapath.sv
/*
 * Multicycle datapath
 * PC, IR, MDR, A, B and ALUOut with their muxes, immediate extension,
 * the ALU and the register file
 */

`timescale 1ns/1ps
`default_nettype none

`include "mipsDefines.svh"

module datapath
(
    input  wire                      clk,
    input  wire                      reset,
    input  mipsPkg::ctrl_t           ctrl,
    input  wire                      pcEn,
    input  mipsPkg::word_t           readData,
    output mipsPkg::opcode_e         opcode,
    output mipsPkg::funct_e          funct,
    output logic                     zero,
    output mipsPkg::memReq_t         memReq,
    input  wire [`MIPS_IO_BITS-1:0]  switches,
    output logic [`MIPS_IO_BITS-1:0] leds
);

    import mipsPkg::*;

    word_t   pc;
    word_t   ir;
    word_t   mdr;
    word_t   regA;
    word_t   regB;
    word_t   aluOut;
    word_t   nextPc;
    word_t   srcA;
    word_t   srcB;
    word_t   aluResult;
    word_t   rd1;
    word_t   rd2;
    word_t   signImm;
    word_t   zeroImm;
    word_t   jumpTarget;
    word_t   writeData;
    regIdx_t writeAddr;

    always_ff @(posedge clk)
    begin
        if (reset)
            pc <= '0;
        else if (pcEn)
            pc <= nextPc;
    end

    always_ff @(posedge clk)
    begin
        if (ctrl.irWrite)
            ir <= readData;
        mdr    <= readData;
        regA   <= rd1;
        regB   <= rd2;
        aluOut <= aluResult;
    end

    assign opcode     = opcode_e'(ir[31:26]);
    assign funct      = funct_e'(ir[5:0]);
    assign signImm    = {{16{ir[15]}}, ir[15:0]};
    assign zeroImm    = {16'b0, ir[15:0]};
    assign jumpTarget = {6'b0, ir[25:0]};   // word address, no shift

    assign srcA = ctrl.aluSrcA ? regA : pc;

    always_comb
    begin
        case (ctrl.aluSrcB)
            2'b00:   srcB = regB;
            2'b01:   srcB = word_t'(1);   // pc steps by one word
            2'b10:   srcB = signImm;
            default: srcB = zeroImm;
        endcase
    end

    always_comb
    begin
        case (ctrl.pcSource)
            2'b01:   nextPc = aluOut;      // branch target from decode
            2'b10:   nextPc = jumpTarget;
            default: nextPc = aluResult;
        endcase
    end

    assign writeAddr = ctrl.regDst ? ir[15:11] : ir[20:16];
    assign writeData = ctrl.memToReg ? mdr : aluOut;

    assign memReq.strobe = ctrl.memWrite;
    assign memReq.addr   = ctrl.iOrD ? aluOut : pc;
    assign memReq.data   = regB;

    alu u_alu
    (
        .a      (srcA),
        .b      (srcB),
        .aluOp  (ctrl.aluOp),
        .result (aluResult),
        .zero   (zero)
    );

    regFile u_regFile
    (
        .clk       (clk),
        .reset     (reset),
        .regWrite  (ctrl.regWrite),
        .readAddr1 (ir[25:21]),
        .readAddr2 (ir[20:16]),
        .writeAddr (writeAddr),
        .writeData (writeData),
        .readData1 (rd1),
        .readData2 (rd2),
        .switches  (switches),
        .leds      (leds)
    );

endmodule

`default_nettype wire

// File: verilog/exMemory.sv
/*
 * External memory
 * 2K words, combinational read, write on the request strobe,
 * preloaded with the program image
 */

`timescale 1ns/1ps
`default_nettype none

`include "mipsDefines.svh"

module exMemory
(
    input  wire              clk,
    input  mipsPkg::memReq_t req,
    output mipsPkg::word_t   readData
);

    import mipsPkg::*;

    localparam int AddrBits = $clog2(`MIPS_MEM_WORDS);

    word_t mem [`MIPS_MEM_WORDS];

    initial
    begin
        $readmemh("program.hex", mem);
    end

    always_ff @(posedge clk)
    begin
        if (req.strobe)
            mem[req.addr[AddrBits-1:0]] <= req.data;
    end

    assign readData = mem[req.addr[AddrBits-1:0]];   // word index, upper bits ignored

endmodule

`default_nettype wire

// File: verilog/mipsTop.sv
/*
 * MIPS system top
 * controller, datapath and external memory; the memory request
 * is also brought out for observation
 */

`timescale 1ns/1ps
`default_nettype none

`include "mipsDefines.svh"

module mipsTop
(
    input  wire                      clk,
    input  wire                      reset,
    input  wire [`MIPS_IO_BITS-1:0]  switches,
    output logic [`MIPS_IO_BITS-1:0] leds,
    output mipsPkg::memReq_t         memWatch
);

    import mipsPkg::*;

    ctrl_t   ctrl;
    logic    pcEn;
    logic    zero;
    opcode_e opcode;
    funct_e  funct;
    word_t   readData;

    controller u_controller
    (
        .clk    (clk),
        .reset  (reset),
        .opcode (opcode),
        .funct  (funct),
        .zero   (zero),
        .ctrl   (ctrl),
        .pcEn   (pcEn)
    );

    datapath u_datapath
    (
        .clk      (clk),
        .reset    (reset),
        .ctrl     (ctrl),
        .pcEn     (pcEn),
        .readData (readData),
        .opcode   (opcode),
        .funct    (funct),
        .zero     (zero),
        .memReq   (memWatch),   // same request feeds the memory
        .switches (switches),
        .leds     (leds)
    );

    exMemory u_exMemory
    (
        .clk      (clk),
        .req      (memWatch),
        .readData (readData)
    );

endmodule

`default_nettype wire

// File: sim/tbMipsTop.sv
/*
 * Testbench for the MIPS system top
 * runs the preloaded program, watches the memory writes it makes
 * and the led register driven from the switches
 */

`timescale 1ns/1ps
`default_nettype none

`include "mipsDefines.svh"

module tbMipsTop;

    import mipsPkg::*;

    localparam int Timeout     = 2000;   // cycles per wait
    localparam int MemAddrBits = $clog2(`MIPS_MEM_WORDS);

    logic                     clk;
    logic                     reset;
    logic [`MIPS_IO_BITS-1:0] switches;
    logic [`MIPS_IO_BITS-1:0] leds;
    memReq_t                  memWatch;

    int     valueErrors;
    int     timeouts;
    integer seed;

    mipsTop u_mipsTop
    (
        .clk      (clk),
        .reset    (reset),
        .switches (switches),
        .leds     (leds),
        .memWatch (memWatch)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic checkWord(input string what, input word_t got, input word_t expected);
        if (got !== expected)
        begin
            $display("FAILED at %0d ns: %s is %h, expected %h", $time, what, got, expected);
            valueErrors++;
        end
    endtask

    task automatic checkReq(input string what, input memReq_t got, input memReq_t expected);
        if (got !== expected)
        begin
            $display("FAILED at %0d ns: %s is strobe %b addr %0d data %h, expected %b %0d %h",
                     $time, what, got.strobe, got.addr, got.data,
                     expected.strobe, expected.addr, expected.data);
            valueErrors++;
        end
    endtask

    task automatic checkLeds(input string what, input logic [`MIPS_IO_BITS-1:0] got,
                             input logic [`MIPS_IO_BITS-1:0] expected);
        if (got !== expected)
        begin
            $display("FAILED at %0d ns: %s is %h, expected %h", $time, what, got, expected);
            valueErrors++;
        end
    endtask

    // sampled mid-cycle, one strobe cycle per write
    task automatic waitStore(output memReq_t req, output bit seen);
        int cycles;
        seen   = 1'b0;
        req    = '0;
        cycles = 0;
        while (!seen && cycles < Timeout)
        begin
            @(negedge clk);
            if (memWatch.strobe === 1'b1)
            begin
                req  = memWatch;
                seen = 1'b1;
            end
            cycles++;
        end
        if (!seen)
        begin
            $display("Timed out after %0d cycles waiting for a memory write", Timeout);
            timeouts++;
        end
    endtask

    task automatic expectStore(input string what, input word_t addr, input word_t data,
                               output bit seen);
        memReq_t got;
        memReq_t expected;
        expected.strobe = 1'b1;
        expected.addr   = addr;
        expected.data   = data;
        waitStore(got, seen);
        if (seen)
        begin
            checkReq(what, got, expected);
            @(negedge clk);   // write has landed by now
            checkWord({what, " in memory"},
                      u_mipsTop.u_exMemory.mem[addr[MemAddrBits-1:0]], data);
        end
    endtask

    task automatic resetTest();
        @(posedge clk);
        @(negedge clk);
        checkLeds("leds in reset", leds, '0);
        checkWord("write strobe in reset", word_t'(memWatch.strobe), '0);
        @(posedge clk);
        #10;
        reset = 1'b0;
        repeat (2)
        begin
            @(negedge clk);
            checkLeds("leds after reset", leds, '0);
            checkWord("write strobe after reset", word_t'(memWatch.strobe), '0);
        end
    endtask

    task automatic aluStoreTest();
        word_t expected [6];
        bit    seen;
        expected[0] = word_t'(7 + 5);
        expected[1] = word_t'(7 - 5);
        expected[2] = word_t'(6 & 3);
        expected[3] = word_t'(6 | 3);
        expected[4] = (-1 < 1) ? 32'd1 : 32'd0;   // signed compare
        expected[5] = 32'h0000_00F0;
        for (int i = 0; i < 6; i++)
        begin
            expectStore($sformatf("ALU store %0d", i), word_t'(100 + i), expected[i], seen);
            if (!seen)
                return;
        end
    endtask

    task automatic loadStoreTest();
        bit seen;
        expectStore("load/store round trip", word_t'(106), word_t'(2 * (7 + 5)), seen);
    endtask

    task automatic branchJumpTest();
        bit seen;
        expectStore("store after taken beq", word_t'(107), word_t'(1), seen);
        if (!seen)
            return;
        expectStore("store after jump", word_t'(108), word_t'(2), seen);
        checkLeds("leds before the led loop", leds, '0);
    endtask

    task automatic ledLoopTest();
        logic [`MIPS_IO_BITS-1:0] value;
        logic [`MIPS_IO_BITS-1:0] expected;
        int                       cycles;
        for (int n = 0; n < 8; n++)
        begin
            value    = `MIPS_IO_BITS'($random(seed));
            expected = value + 1'b1;   // wraps at 16 bits
            @(posedge clk);
            #10;
            switches = value;
            cycles   = 0;
            while (leds !== expected && cycles < Timeout)
            begin
                @(negedge clk);
                cycles++;
            end
            if (cycles >= Timeout)
            begin
                $display("Timed out after %0d cycles waiting for leds to follow switches %h",
                         Timeout, value);
                timeouts++;
                checkLeds("leds for switches + 1", leds, expected);
                return;
            end
            // holds through another pass of the loop
            repeat (8)
            begin
                @(negedge clk);
                checkLeds("leds for switches + 1", leds, expected);
            end
        end
    endtask

    // the skipped stores must never reach memory
    always @(negedge clk)
    begin
        if (memWatch.strobe === 1'b1 && memWatch.data === 32'h0000_0BAD)
        begin
            $display("FAILED at %0d ns: store of 0xbad to address %0d", $time, memWatch.addr);
            valueErrors++;
        end
    end

    initial
    begin
        valueErrors = 0;
        timeouts    = 0;
        seed        = 32'h4031;
        reset       = 1'b1;
        switches    = '0;

        resetTest();
        aluStoreTest();
        loadStoreTest();
        branchJumpTest();
        ledLoopTest();

        $display("Summary: %0d value errors, %0d timeouts", valueErrors, timeouts);
        if (valueErrors == 0 && timeouts == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/program.hex
// one 32-bit instruction word per line, loaded from word address 0
// data stores land at word addresses 100 to 108
20010007 // addi r1, r0, 7
20020005 // addi r2, r0, 5
00221820 // add  r3, r1, r2
AC030064 // sw   r3, 100(r0)
00221822 // sub  r3, r1, r2
AC030065 // sw   r3, 101(r0)
20040006 // addi r4, r0, 6
20050003 // addi r5, r0, 3
00851824 // and  r3, r4, r5
AC030066 // sw   r3, 102(r0)
00851825 // or   r3, r4, r5
AC030067 // sw   r3, 103(r0)
2006FFFF // addi r6, r0, -1
20070001 // addi r7, r0, 1
00C7182A // slt  r3, r6, r7
AC030068 // sw   r3, 104(r0)
340300F0 // ori  r3, r0, 0x00f0
AC030069 // sw   r3, 105(r0)
8C080064 // lw   r8, 100(r0)
01084820 // add  r9, r8, r8
AC09006A // sw   r9, 106(r0)
200A0BAD // addi r10, r0, 0xbad
10210001 // beq  r1, r1, +1
AC0A006B // sw   r10, 107(r0), skipped
AC07006B // sw   r7, 107(r0)
0800001B // j    27
AC0A006C // sw   r10, 108(r0), skipped
200B0002 // addi r11, r0, 2
AC0B006C // sw   r11, 108(r0)
21CF0001 // addi r15, r14, 1
0800001D // j    29

// File: tb.f
+incdir+common
common/mipsPkg.sv
cpu/alu.sv
cpu/regFile.sv
cpu/controller.sv
cpu/datapath.sv
verilog/exMemory.sv
verilog/mipsTop.sv
sim/tbMipsTop.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tbMipsTop
FILELIST  = tb.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# the memory image is read from the working directory, so run from sim/
run: compile
	cd sim && ../$(OBJDIR)/V$(TOP) > ../$(LOG) 2>&1; cat $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
